//--- hw/status_pkg.sv
// shared widths, address map, register layout and fixed words of the status bus; import by wildcard
package status_pkg;

	localparam int ADDR_W    = 16;
	localparam int DATA_W    = 32;
	localparam int REG_OFS_W = 3; // local word offset inside a client window

	typedef logic [ADDR_W-1:0] status_addr_t;
	typedef logic [DATA_W-1:0] status_data_t;

	////////////////////////////////
	// address map
	////////////////////////////////
	localparam status_addr_t OPTICS_BASE  = 16'h0400; // three words used
	localparam status_addr_t SCRATCH_BASE = 16'h0500; // eight words

	localparam logic [REG_OFS_W-1:0] OPT_CTRL_OFS = 3'd0;
	localparam logic [REG_OFS_W-1:0] OPT_STAT_OFS = 3'd1;
	localparam logic [REG_OFS_W-1:0] OPT_ALRM_OFS = 3'd2;

	////////////////////////////////
	// optics register layout
	////////////////////////////////
	localparam int PRG_W  = 3; // programmable control and alarm pins
	localparam int CTRL_W = 6;
	localparam int STAT_W = 6;
	localparam int ALRM_W = 5;

	localparam int CTRL_LOPWR_BIT     = 0;
	localparam int CTRL_MOD_RST_N_BIT = 1;
	localparam int CTRL_TX_DIS_BIT    = 2;
	localparam int CTRL_PRG_LSB       = 3; // bits 5:3

	localparam int STAT_MOD_ABS_BIT  = 0;
	localparam int STAT_RX_LOS_BIT   = 1;
	localparam int STAT_GLB_ALRM_BIT = 2;
	localparam int STAT_PRG_LSB      = 3; // bits 5:3

	localparam int ALRM_RX_LOS_BIT   = 0;
	localparam int ALRM_GLB_ALRM_BIT = 1;
	localparam int ALRM_PRG_LSB      = 2; // bits 4:2

	// low power, module in reset, tx disabled
	localparam status_data_t OPT_CTRL_RESET = 32'h0000_0005;

	////////////////////////////////
	// fixed words and timing
	////////////////////////////////
	localparam status_data_t STATUS_ID     = 32'h4045_0001;
	localparam status_data_t UNMAPPED_DATA = 32'hDEAD_BEEF;
	localparam int READ_LATENCY = 3; // strobe to readdata_valid, cycles
	localparam int SYNC_STAGES  = 2;

endpackage

//--- hw/status_addr_decode.sv
// first stage of the status bus: registers host strobes and splits them into per-client strobes
`timescale 1ns/1ps

module status_addr_decode import status_pkg::*; (
	input  logic                 clk_status,
	input  logic                 arst,
	input  status_addr_t         status_addr,
	input  logic                 status_read,
	input  logic                 status_write,
	input  status_data_t         status_writedata,
	output logic                 opt_read,
	output logic                 opt_write,
	output logic                 scr_read,
	output logic                 scr_write,
	output logic                 miss,
	output logic [REG_OFS_W-1:0] reg_ofs,
	output status_data_t         wdata
);

	logic opt_hit;
	logic scr_hit;
	logic miss_pend; // unmapped read seen, waits one cycle to line up with clients

	////////////////////////////////
	// window compare on the raw address
	////////////////////////////////
	// optics window holds ctrl, stat and alarm only, offsets 3..7 are unmapped
	assign opt_hit = (status_addr[ADDR_W-1:REG_OFS_W] == OPTICS_BASE[ADDR_W-1:REG_OFS_W]) &&
		(status_addr[REG_OFS_W-1:0] <= OPT_ALRM_OFS);
	assign scr_hit = (status_addr[ADDR_W-1:REG_OFS_W] == SCRATCH_BASE[ADDR_W-1:REG_OFS_W]);

	////////////////////////////////
	// registered strobes
	////////////////////////////////
	always_ff @(posedge clk_status) begin
		if (arst) begin
			opt_read  <= 1'b0;
			opt_write <= 1'b0;
			scr_read  <= 1'b0;
			scr_write <= 1'b0;
			miss_pend <= 1'b0;
			miss      <= 1'b0;
		end else begin
			opt_read  <= status_read  && opt_hit;
			opt_write <= status_write && opt_hit;
			scr_read  <= status_read  && scr_hit;
			scr_write <= status_write && scr_hit; // id word write dropped by the client
			miss_pend <= status_read && !opt_hit && !scr_hit;
			miss      <= miss_pend; // same cycle as a client rvalid would be
		end
	end

	// offset and data for whichever client is strobed
	always_ff @(posedge clk_status) begin
		reg_ofs <= status_addr[REG_OFS_W-1:0];
		wdata   <= status_writedata;
	end

endmodule

//--- hw/optics_ctrl_regs.sv
// optics module register client: control pins, synchronized status inputs and sticky alarms
`timescale 1ns/1ps

module optics_ctrl_regs import status_pkg::*; (
	input  logic                 clk_status,
	input  logic                 arst,
	input  logic                 read,
	input  logic                 write,
	input  logic [REG_OFS_W-1:0] reg_ofs,
	input  status_data_t         wdata,
	input  logic                 cfp_mod_abs,
	input  logic                 cfp_rx_los,
	input  logic                 cfp_glb_alrm,
	input  logic [PRG_W-1:0]     cfp_prg_alrm,
	output status_data_t         rdata,
	output logic                 rvalid,
	output logic                 cfp_mod_lopwr,
	output logic                 cfp_mod_rst,   // active low
	output logic                 cfp_tx_dis,
	output logic [PRG_W-1:0]     cfp_prg_cntl
);

	logic [CTRL_W-1:0] ctrl_q;
	logic [STAT_W-1:0] stat_raw;               // pins packed in status word order
	logic [STAT_W-1:0] sync_q [SYNC_STAGES];
	logic [STAT_W-1:0] stat;                   // live status after sync
	logic [ALRM_W-1:0] alrm_src;
	logic [ALRM_W-1:0] alrm_clr;
	logic [ALRM_W-1:0] alrm_q;

	////////////////////////////////
	// control register and pins
	////////////////////////////////
	always_ff @(posedge clk_status) begin
		if (arst) begin
			ctrl_q <= OPT_CTRL_RESET[CTRL_W-1:0];
		end else if (write && (reg_ofs == OPT_CTRL_OFS)) begin
			ctrl_q <= wdata[CTRL_W-1:0];
		end
	end

	assign cfp_mod_lopwr = ctrl_q[CTRL_LOPWR_BIT];
	assign cfp_mod_rst   = ctrl_q[CTRL_MOD_RST_N_BIT]; // 0 holds the module in reset
	assign cfp_tx_dis    = ctrl_q[CTRL_TX_DIS_BIT];
	assign cfp_prg_cntl  = ctrl_q[CTRL_PRG_LSB +: PRG_W];

	////////////////////////////////
	// input synchronizers
	////////////////////////////////
	always_comb begin
		stat_raw = '0;
		stat_raw[STAT_MOD_ABS_BIT]        = cfp_mod_abs;
		stat_raw[STAT_RX_LOS_BIT]         = cfp_rx_los;
		stat_raw[STAT_GLB_ALRM_BIT]       = cfp_glb_alrm;
		stat_raw[STAT_PRG_LSB +: PRG_W]   = cfp_prg_alrm;
	end

	always_ff @(posedge clk_status) begin
		if (arst) begin
			for (int i = 0; i < SYNC_STAGES; i++) sync_q[i] <= '0;
		end else begin
			sync_q[0] <= stat_raw; // pins are async to clk_status
			for (int i = 1; i < SYNC_STAGES; i++) sync_q[i] <= sync_q[i-1];
		end
	end

	assign stat = sync_q[SYNC_STAGES-1];

	////////////////////////////////
	// sticky alarms
	////////////////////////////////
	always_comb begin
		alrm_src = '0;
		alrm_src[ALRM_RX_LOS_BIT]        = stat[STAT_RX_LOS_BIT];
		alrm_src[ALRM_GLB_ALRM_BIT]      = stat[STAT_GLB_ALRM_BIT];
		alrm_src[ALRM_PRG_LSB +: PRG_W]  = stat[STAT_PRG_LSB +: PRG_W];
	end

	// write 1 to clear
	assign alrm_clr = (write && (reg_ofs == OPT_ALRM_OFS)) ? wdata[ALRM_W-1:0] : '0;

	always_ff @(posedge clk_status) begin
		if (arst) alrm_q <= '0;
		else      alrm_q <= (alrm_q & ~alrm_clr) | alrm_src; // live source wins over clear
	end

	////////////////////////////////
	// read port, one cycle
	////////////////////////////////
	always_ff @(posedge clk_status) begin
		if (arst) rvalid <= 1'b0;
		else      rvalid <= read;
	end

	always_ff @(posedge clk_status) begin
		if (read) begin
			case (reg_ofs)
				OPT_CTRL_OFS: rdata <= status_data_t'(ctrl_q);
				OPT_STAT_OFS: rdata <= status_data_t'(stat);
				OPT_ALRM_OFS: rdata <= status_data_t'(alrm_q);
				default:      rdata <= '0; // decode never strobes these
			endcase
		end
	end

endmodule

//--- hw/status_scratch_regs.sv
// identification and scratch register client, id word at offset 0 and seven read/write words
`timescale 1ns/1ps

module status_scratch_regs import status_pkg::*; (
	input  logic                 clk_status,
	input  logic                 arst,
	input  logic                 read,
	input  logic                 write,
	input  logic [REG_OFS_W-1:0] reg_ofs,
	input  status_data_t         wdata,
	output status_data_t         rdata,
	output logic                 rvalid
);

	status_data_t scr_q [1:7]; // offset 0 is the fixed id word
	logic         id_sel;

	assign id_sel = (reg_ofs == '0);

	////////////////////////////////
	// scratch words
	////////////////////////////////
	always_ff @(posedge clk_status) begin
		if (arst) begin
			for (int i = 1; i < 8; i++) scr_q[i] <= '0;
		end else if (write && !id_sel) begin
			scr_q[reg_ofs] <= wdata;
		end
		// writes to the id word fall through here
	end

	////////////////////////////////
	// read port
	////////////////////////////////
	always_ff @(posedge clk_status) begin
		if (arst) rvalid <= 1'b0;
		else      rvalid <= read;
	end

	always_ff @(posedge clk_status) begin
		if (read) begin
			if (id_sel) rdata <= STATUS_ID;
			else        rdata <= scr_q[reg_ofs];
		end
	end

endmodule

//--- hw/status_read_combine.sv
// result stage of the status bus: merges client read data and answers unmapped reads
`timescale 1ns/1ps

module status_read_combine import status_pkg::*; (
	input  logic         clk_status,
	input  logic         arst,
	input  status_data_t opt_rdata,
	input  logic         opt_rvalid,
	input  status_data_t scr_rdata,
	input  logic         scr_rvalid,
	input  logic         miss,
	output status_data_t status_readdata,
	output logic         status_readdata_valid
);

	status_data_t opt_term;
	status_data_t scr_term;
	status_data_t miss_term;
	status_data_t merged;
	logic         any_valid;

	////////////////////////////////
	// masked OR of all sources
	////////////////////////////////
	// only one source answers per cycle; a collision ORs the words
	always_comb begin
		opt_term  = opt_rvalid ? opt_rdata : '0;
		scr_term  = scr_rvalid ? scr_rdata : '0;
		miss_term = miss ? UNMAPPED_DATA : '0; // fixed pattern for holes in the map
		merged    = opt_term | scr_term | miss_term;
	end

	assign any_valid = opt_rvalid | scr_rvalid | miss;

	////////////////////////////////
	// output register
	////////////////////////////////
	always_ff @(posedge clk_status) begin
		if (arst) status_readdata_valid <= 1'b0;
		else      status_readdata_valid <= any_valid; // single pulse per read
	end

	// data holds the last answer between reads
	always_ff @(posedge clk_status) begin
		if (any_valid) status_readdata <= merged;
	end

endmodule

//--- hw/status_subsystem_top.sv
// top of the status register subsystem: decode, optics and scratch clients, read combiner
`timescale 1ns/1ps

module status_subsystem_top import status_pkg::*; (
	input  logic             clk_status,
	input  logic             arst,
	// host bus
	input  status_addr_t     status_addr,
	input  logic             status_read,
	input  logic             status_write,
	input  status_data_t     status_writedata,
	output status_data_t     status_readdata,
	output logic             status_readdata_valid,
	// CFP pins
	input  logic             cfp_mod_abs,
	input  logic             cfp_rx_los,
	input  logic             cfp_glb_alrm,
	input  logic [PRG_W-1:0] cfp_prg_alrm,
	output logic             cfp_mod_lopwr,
	output logic             cfp_mod_rst,   // active low
	output logic             cfp_tx_dis,
	output logic [PRG_W-1:0] cfp_prg_cntl
);

	logic                 opt_read;
	logic                 opt_write;
	logic                 scr_read;
	logic                 scr_write;
	logic                 miss;
	logic [REG_OFS_W-1:0] reg_ofs;
	status_data_t         wdata;
	status_data_t         opt_rdata;
	logic                 opt_rvalid;
	status_data_t         scr_rdata;
	logic                 scr_rvalid;

	////////////////////////////////
	// decode
	////////////////////////////////
	status_addr_decode i_decode (
		.clk_status       (clk_status),
		.arst             (arst),
		.status_addr      (status_addr),
		.status_read      (status_read),
		.status_write     (status_write),
		.status_writedata (status_writedata),
		.opt_read         (opt_read),
		.opt_write        (opt_write),
		.scr_read         (scr_read),
		.scr_write        (scr_write),
		.miss             (miss),
		.reg_ofs          (reg_ofs),
		.wdata            (wdata)
	);

	////////////////////////////////
	// clients
	////////////////////////////////
	optics_ctrl_regs i_optics (
		.clk_status    (clk_status),
		.arst          (arst),
		.read          (opt_read),
		.write         (opt_write),
		.reg_ofs       (reg_ofs),
		.wdata         (wdata),
		.cfp_mod_abs   (cfp_mod_abs),
		.cfp_rx_los    (cfp_rx_los),
		.cfp_glb_alrm  (cfp_glb_alrm),
		.cfp_prg_alrm  (cfp_prg_alrm),
		.rdata         (opt_rdata),
		.rvalid        (opt_rvalid),
		.cfp_mod_lopwr (cfp_mod_lopwr),
		.cfp_mod_rst   (cfp_mod_rst),
		.cfp_tx_dis    (cfp_tx_dis),
		.cfp_prg_cntl  (cfp_prg_cntl)
	);

	status_scratch_regs i_scratch (
		.clk_status (clk_status),
		.arst       (arst),
		.read       (scr_read),
		.write      (scr_write),
		.reg_ofs    (reg_ofs),
		.wdata      (wdata),
		.rdata      (scr_rdata),
		.rvalid     (scr_rvalid)
	);

	////////////////////////////////
	// merge read data
	////////////////////////////////
	status_read_combine i_combine (
		.clk_status            (clk_status),
		.arst                  (arst),
		.opt_rdata             (opt_rdata),
		.opt_rvalid            (opt_rvalid),
		.scr_rdata             (scr_rdata),
		.scr_rvalid            (scr_rvalid),
		.miss                  (miss),
		.status_readdata       (status_readdata),
		.status_readdata_valid (status_readdata_valid)
	);

endmodule

//--- test/status_bus_asserts.sv
// protocol and latency checks on the status bus, attached by bind from the testbench
`timescale 1ns/1ps

module status_bus_asserts import status_pkg::*; (
	input logic clk_status,
	input logic arst,
	input logic status_read,
	input logic opt_rvalid,
	input logic scr_rvalid,
	input logic miss,
	input logic status_readdata_valid
);

	int   fail_cnt = 0; // read back by the testbench summary
	logic any_src;

	assign any_src = opt_rvalid | scr_rvalid | miss;

	////////////////////////////////
	// response path
	////////////////////////////////
	// every read strobe answers after READ_LATENCY, mapped or not
	a_read_to_valid: assert property (@(posedge clk_status) disable iff (arst)
		status_read |-> ##READ_LATENCY status_readdata_valid)
	else begin
		$error("read strobe not followed by readdata_valid");
		fail_cnt++;
	end

	// no output pulse without a read strobe behind it
	a_no_orphan: assert property (@(posedge clk_status) disable iff (arst)
		status_readdata_valid |-> $past(status_read, READ_LATENCY))
	else begin
		$error("readdata_valid without a read strobe");
		fail_cnt++;
	end

	a_one_source: assert property (@(posedge clk_status) disable iff (arst)
		$onehot0({opt_rvalid, scr_rvalid, miss}))
	else begin
		$error("two read sources answered in one cycle");
		fail_cnt++;
	end

	// quiet once reset has been seen for a full cycle
	a_reset_quiet: assert property (@(posedge clk_status)
		(arst && $past(arst)) |-> (!any_src && !status_readdata_valid))
	else begin
		$error("valid high during reset");
		fail_cnt++;
	end

endmodule

//--- test/tb_status_subsystem.sv
// testbench of the status register subsystem: host bus stimulus, reference model and checks
`timescale 1ns/1ps

module tb_status_subsystem import status_pkg::*; ();

	localparam int RESET_CYCLES = 10;
	localparam int N_CTRL       = 4;  // control word rounds
	localparam int N_CFP        = 4;  // CFP input rounds
	localparam int N_MISS       = 6;  // random unmapped reads
	localparam int N_OPS        = 1 + 3 + 14 + 2 * N_CTRL + 12 * N_CFP + 5 + N_MISS;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + N_OPS * 10 + 100;

	logic             clk_status = 1'b0;
	logic             arst;
	status_addr_t     status_addr;
	logic             status_read;
	logic             status_write;
	status_data_t     status_writedata;
	status_data_t     status_readdata;
	logic             status_readdata_valid;
	logic             cfp_mod_abs;
	logic             cfp_rx_los;
	logic             cfp_glb_alrm;
	logic [PRG_W-1:0] cfp_prg_alrm;
	logic             cfp_mod_lopwr;
	logic             cfp_mod_rst;
	logic             cfp_tx_dis;
	logic [PRG_W-1:0] cfp_prg_cntl;

	// reference model state
	status_data_t      scr_model [1:7];
	status_data_t      ctrl_model;
	logic [ALRM_W-1:0] alrm_model;
	status_data_t      exp_q [$];   // expected words, issue order
	int                issue_q [$]; // cycle of each read strobe

	int          seed = 32'h1ff7_59d7;
	logic [31:0] rnd;
	int          cycle_cnt = 0;
	int          error_cnt = 0;
	int          check_cnt = 0;
	int          assert_fails;

	status_subsystem_top i_dut (.*);

	bind status_subsystem_top status_bus_asserts i_asserts (.*);

	always #5 clk_status = ~clk_status;

	always @(posedge clk_status) cycle_cnt <= cycle_cnt + 1;

	//////////////////////////////
	// reference model
	//////////////////////////////
	function automatic status_addr_t reg_addr(status_addr_t base, logic [REG_OFS_W-1:0] ofs);
		return {base[ADDR_W-1:REG_OFS_W], ofs};
	endfunction

	function automatic logic is_mapped(status_addr_t addr);
		if (addr[ADDR_W-1:REG_OFS_W] == SCRATCH_BASE[ADDR_W-1:REG_OFS_W]) return 1'b1;
		if (addr[ADDR_W-1:REG_OFS_W] == OPTICS_BASE[ADDR_W-1:REG_OFS_W])
			return addr[REG_OFS_W-1:0] <= OPT_ALRM_OFS; // ctrl, stat, alarm
		return 1'b0;
	endfunction

	function automatic status_data_t stat_word();
		status_data_t w;
		w = '0;
		w[STAT_MOD_ABS_BIT]      = cfp_mod_abs;
		w[STAT_RX_LOS_BIT]       = cfp_rx_los;
		w[STAT_GLB_ALRM_BIT]     = cfp_glb_alrm;
		w[STAT_PRG_LSB +: PRG_W] = cfp_prg_alrm;
		return w;
	endfunction

	function automatic logic [ALRM_W-1:0] alarm_src();
		logic [ALRM_W-1:0] s;
		s = '0;
		s[ALRM_RX_LOS_BIT]       = cfp_rx_los; // mod_abs has no sticky bit
		s[ALRM_GLB_ALRM_BIT]     = cfp_glb_alrm;
		s[ALRM_PRG_LSB +: PRG_W] = cfp_prg_alrm;
		return s;
	endfunction

	function automatic status_data_t exp_read(status_addr_t addr);
		logic [REG_OFS_W-1:0] ofs;
		ofs = addr[REG_OFS_W-1:0];
		if (!is_mapped(addr)) return UNMAPPED_DATA;
		if (addr[ADDR_W-1:REG_OFS_W] == SCRATCH_BASE[ADDR_W-1:REG_OFS_W])
			return (ofs == 3'd0) ? STATUS_ID : scr_model[ofs];
		if (ofs == OPT_CTRL_OFS) return ctrl_model;
		if (ofs == OPT_STAT_OFS) return stat_word();
		return status_data_t'(alrm_model);
	endfunction

	task automatic update_model(status_addr_t addr, status_data_t data);
		logic [REG_OFS_W-1:0] ofs;
		ofs = addr[REG_OFS_W-1:0];
		if (!is_mapped(addr)) return;
		if (addr[ADDR_W-1:REG_OFS_W] == SCRATCH_BASE[ADDR_W-1:REG_OFS_W]) begin
			if (ofs != 3'd0) scr_model[ofs] = data; // id word is read-only
		end else if (ofs == OPT_CTRL_OFS) begin
			ctrl_model = status_data_t'(data[CTRL_W-1:0]);
		end else if (ofs == OPT_ALRM_OFS) begin
			alrm_model = (alrm_model & ~data[ALRM_W-1:0]) | alarm_src(); // live source sets again
		end
	endtask

	//////////////////////////////
	// compare tasks
	//////////////////////////////
	task automatic check_word(status_data_t got, status_data_t exp, string what);
		check_cnt++;
		if (got !== exp) begin
			error_cnt++;
			$display("** Error at time %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_pins(status_data_t ctrl);
		check_cnt++;
		if (cfp_mod_lopwr !== ctrl[CTRL_LOPWR_BIT] || cfp_mod_rst !== ctrl[CTRL_MOD_RST_N_BIT] ||
			cfp_tx_dis !== ctrl[CTRL_TX_DIS_BIT] ||
			cfp_prg_cntl !== ctrl[CTRL_PRG_LSB +: PRG_W]) begin
			error_cnt++;
			$display("** Error at time %0t: CFP pins lopwr %b rst_n %b tx_dis %b prg %b, ctrl %h",
				$time, cfp_mod_lopwr, cfp_mod_rst, cfp_tx_dis, cfp_prg_cntl, ctrl);
		end
	endtask

	task automatic check_latency(int got);
		check_cnt++;
		if (got != READ_LATENCY) begin
			error_cnt++;
			$display("** Error at time %0t: read latency %0d cycles expected %0d",
				$time, got, READ_LATENCY);
		end
	endtask

	// outputs are registered, so the falling edge sees them settled
	always @(negedge clk_status) begin
		if (!arst && status_readdata_valid) begin
			if (exp_q.size() == 0) begin
				error_cnt++;
				$display("readdata_valid arrived at time %0t with no read pending", $time);
			end else begin
				check_word(status_readdata, exp_q.pop_front(), "read data");
				check_latency(cycle_cnt - issue_q.pop_front());
			end
		end
	end

	//////////////////////////////
	// bus tasks, entered on a falling edge
	//////////////////////////////
	task automatic idle(int n);
		repeat (n) @(negedge clk_status);
	endtask

	task automatic bus_write(status_addr_t addr, status_data_t data);
		status_addr      = addr;
		status_writedata = data;
		status_write     = 1'b1;
		@(negedge clk_status);
		status_write = 1'b0;
		update_model(addr, data);
	endtask

	task automatic bus_read(status_addr_t addr);
		status_addr = addr;
		status_read = 1'b1;
		exp_q.push_back(exp_read(addr));
		issue_q.push_back(cycle_cnt);
		@(negedge clk_status);
		status_read = 1'b0;
	endtask

	task automatic apply_cfp(logic [5:0] pins);
		cfp_mod_abs  = pins[0];
		cfp_rx_los   = pins[1];
		cfp_glb_alrm = pins[2];
		cfp_prg_alrm = pins[5:3];
		idle(5); // past both sync stages and the alarm latch
		alrm_model = alrm_model | alarm_src();
	endtask

	//////////////////////////////
	// stimulus
	//////////////////////////////
	initial begin
		arst             = 1'b1;
		status_addr      = '0;
		status_read      = 1'b0;
		status_write     = 1'b0;
		status_writedata = '0;
		cfp_mod_abs      = 1'b0;
		cfp_rx_los       = 1'b0;
		cfp_glb_alrm     = 1'b0;
		cfp_prg_alrm     = '0;
		for (int i = 1; i < 8; i++) scr_model[i] = '0;
		ctrl_model = OPT_CTRL_RESET;
		alrm_model = '0;
		repeat (RESET_CYCLES) @(posedge clk_status);
		@(negedge clk_status);
		arst = 1'b0;

		// reset state of the control pins
		check_pins(ctrl_model);
		bus_read(reg_addr(OPTICS_BASE, OPT_CTRL_OFS));

		// id word ignores writes
		bus_read(SCRATCH_BASE);
		rnd = $random(seed);
		bus_write(SCRATCH_BASE, rnd);
		bus_read(SCRATCH_BASE);

		// scratch fill, then back-to-back readback
		for (int i = 1; i < 8; i++) begin
			rnd = $random(seed);
			bus_write(reg_addr(SCRATCH_BASE, 3'(i)), rnd);
		end
		for (int i = 1; i < 8; i++) bus_read(reg_addr(SCRATCH_BASE, 3'(i)));

		// control word to pins
		repeat (N_CTRL) begin
			rnd = $random(seed);
			bus_write(reg_addr(OPTICS_BASE, OPT_CTRL_OFS), rnd);
			idle(1);
			check_pins(ctrl_model);
			bus_read(reg_addr(OPTICS_BASE, OPT_CTRL_OFS));
		end

		// status inputs and sticky alarms
		repeat (N_CFP) begin
			rnd = $random(seed);
			apply_cfp(rnd[5:0]);
			bus_read(reg_addr(OPTICS_BASE, OPT_STAT_OFS));
			bus_read(reg_addr(OPTICS_BASE, OPT_ALRM_OFS));
			apply_cfp(6'b0); // alarms stay latched
			bus_read(reg_addr(OPTICS_BASE, OPT_ALRM_OFS));
			rnd = $random(seed);
			apply_cfp(rnd[5:0]);
			bus_write(reg_addr(OPTICS_BASE, OPT_ALRM_OFS), 32'h1F);
			bus_read(reg_addr(OPTICS_BASE, OPT_ALRM_OFS));
			bus_read(reg_addr(OPTICS_BASE, OPT_STAT_OFS));
		end

		// holes in the map
		for (int o = 3; o < 8; o++) bus_read(reg_addr(OPTICS_BASE, 3'(o)));
		repeat (N_MISS) begin
			do begin
				rnd = $random(seed);
			end while (is_mapped(rnd[ADDR_W-1:0]));
			bus_read(rnd[ADDR_W-1:0]);
		end

		while (exp_q.size() != 0) @(negedge clk_status);
		idle(4);
		assert_fails = i_dut.i_asserts.fail_cnt;
		$display("checks %0d, errors %0d, assertion failures %0d",
			check_cnt, error_cnt, assert_fails);
		if (error_cnt == 0 && assert_fails == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	// bounded by the issued operation count
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_status);
		$display("watchdog expired after %0d cycles, %0d reads still pending",
			WATCHDOG_CYCLES, exp_q.size());
		$display("Something failed");
		$finish;
	end

endmodule

//--- status_bus.f
hw/status_pkg.sv
hw/status_addr_decode.sv
hw/optics_ctrl_regs.sv
hw/status_scratch_regs.sv
hw/status_read_combine.sv
hw/status_subsystem_top.sv
test/status_bus_asserts.sv
test/tb_status_subsystem.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 -f status_bus.f \
	--top-module tb_status_subsystem \
	&& ./obj_dir/Vtb_status_subsystem +verilator+error+limit+1000 > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "^Everything OK$" sim.log && exit 0 || exit 1
